// ==== src/mem_sched_defines.svh ====
// Width and geometry macros of the memory scheduler, included by the package and the RTL

`ifndef MEM_SCHED_DEFINES_SVH
`define MEM_SCHED_DEFINES_SVH

// Address and parameter register width
`define MS_ADDR_W 32

// Iteration counters, also the width of each half of an iteration register
`define MS_ITER_W 16

// Rows of the compute array read per X tile
`define MS_ARRAY_W 4

// Byte step between consecutive column tiles
`define MS_TILE_JMP 64

// Group index width, the skip bit travels next to it
`define MS_GIDX_W 8

// Parameter register file
`define MS_NUM_REGS 16
`define MS_REG_AW 4

`endif

// ==== src/mem_sched_pkg.sv ====
// Shared types of the memory scheduler, imported by the RTL and the testbench

`include "mem_sched_defines.svh"

package mem_sched_pkg;

  typedef enum logic [1:0] {
    QINT_8 = 2'd0,
    QINT_4 = 2'd1,
    QINT_2 = 2'd2
  } qint_fmt_e;

  typedef enum logic [`MS_REG_AW-1:0] {
    X_ADDR      = 4'd0,
    W_ADDR      = 4'd1,
    Z_ADDR      = 4'd2,
    SCALES_ADDR = 4'd3,
    ZEROS_ADDR  = 4'd4,
    GIDX_ADDR   = 4'd5,
    X_ITERS     = 4'd6,
    W_ITERS     = 4'd7,
    X_ROWS_OFFS = 4'd8,
    X_D1_STRIDE = 4'd9,
    W_D0_STRIDE = 4'd10,
    W_TOT_LEN   = 4'd11,
    Z_TOT_LEN   = 4'd12,
    Z_D0_STRIDE = 4'd13,
    TOT_X_READ  = 4'd14,
    MODE        = 4'd15
  } param_idx_e;

  typedef logic [`MS_NUM_REGS-1:0][`MS_ADDR_W-1:0] sched_regs_t;

  // Layout of the X_ITERS and W_ITERS registers
  typedef struct packed {
    logic [`MS_ITER_W-1:0] hi;
    logic [`MS_ITER_W-1:0] lo;
  } iters_reg_t;

  // Layout of the MODE register
  typedef struct packed {
    logic [7:0]  leftover;
    logic [20:0] rsvd;
    qint_fmt_e   fmt;
    logic        dequant_en;
  } mode_reg_t;

  typedef struct packed {
    logic [`MS_ADDR_W-1:0] base_addr;
    logic [`MS_ADDR_W-1:0] tot_len;
    logic [`MS_ADDR_W-1:0] d0_len;
    logic [`MS_ADDR_W-1:0] d0_stride;
    logic [`MS_ADDR_W-1:0] d1_len;
    logic [`MS_ADDR_W-1:0] d1_stride;
    logic [`MS_ADDR_W-1:0] d2_stride;
    logic [2:0]            dim_enable;
  } addrgen_cfg_t;

  typedef struct packed {
    addrgen_cfg_t cfg;
    logic         req_start;
  } stream_ctrl_t;

  typedef struct packed {
    logic ready_start;
    logic done;
  } stream_flags_t;

  typedef struct packed {
    logic                  skip;
    logic [`MS_GIDX_W-1:0] index;
  } gidx_beat_t;

  typedef struct packed {
    logic [`MS_ADDR_W-1:0] scales_bias;
    logic [`MS_ADDR_W-1:0] zeros_bias;
    logic                  skip;
  } dequant_off_t;

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`MS_REG_AW-1:0] adr;
    logic [`MS_ADDR_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic [`MS_ADDR_W-1:0] dat;
  } wb_rsp_t;

  // Packed weights are narrower, so their strides shrink with the format
  function automatic logic [1:0] get_q_shift(qint_fmt_e fmt);
    case (fmt)
      QINT_2:  return 2'd3;
      QINT_4:  return 2'd2;
      default: return 2'd1;
    endcase
  endfunction

endpackage

// ==== src/sched_param_regs.sv ====
// Wishbone classic slave holding the job parameters, read back and written with a 1-cycle ack

`timescale 1ns/1ns

`include "mem_sched_defines.svh"

module sched_param_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  mem_sched_pkg::wb_req_t    wb_req_i,
  output mem_sched_pkg::wb_rsp_t    wb_rsp_o,
  output mem_sched_pkg::sched_regs_t regs_o
);
  import mem_sched_pkg::*;

  sched_regs_t           regs_q;
  logic                  ack_q;
  logic [`MS_ADDR_W-1:0] rdata_q;
  logic                  req_active;

  // A new request is only taken once the previous ack is gone
  assign req_active = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_active;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regs_q <= '0;
    end else if (req_active && wb_req_i.we) begin
      regs_q[wb_req_i.adr] <= wb_req_i.dat;
    end
  end

  // Read data is captured with the request and presented together with ack
  always_ff @(posedge clk_i) begin
    if (req_active) begin
      rdata_q <= regs_q[wb_req_i.adr];
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdata_q;
  assign regs_o       = regs_q;

endmodule

// ==== src/tile_iter_counter.sv ====
// Nested tile counters of the X matrix, producing the X stream config and its start request

`timescale 1ns/1ns

`include "mem_sched_defines.svh"

module tile_iter_counter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  mem_sched_pkg::sched_regs_t  regs_i,
  input  logic                        first_load_i,
  input  mem_sched_pkg::stream_flags_t x_flags_i,
  output mem_sched_pkg::stream_ctrl_t x_ctrl_o
);
  import mem_sched_pkg::*;

  iters_reg_t            x_iters;
  iters_reg_t            w_iters;
  mode_reg_t             mode;

  logic [`MS_ITER_W-1:0] col_cnt_q;
  logic [`MS_ITER_W-1:0] w_cnt_q;
  logic [`MS_ITER_W-1:0] row_cnt_q;
  logic [`MS_ADDR_W-1:0] col_offs_q;
  logic [`MS_ADDR_W-1:0] row_offs_q;
  logic [`MS_ADDR_W-1:0] tot_read_q;

  logic                  cols_last;
  logic                  w_last;
  logic                  rows_last;

  assign x_iters = iters_reg_t'(regs_i[X_ITERS]);
  assign w_iters = iters_reg_t'(regs_i[W_ITERS]);
  assign mode    = mode_reg_t'(regs_i[MODE]);

  assign cols_last = col_cnt_q == x_iters.lo - 1'b1;
  assign w_last    = w_cnt_q == w_iters.lo - 1'b1;
  assign rows_last = row_cnt_q == x_iters.hi - 1'b1;

  // Columns run fastest, then W iterations, then X rows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_cnt_q  <= '0;
      w_cnt_q    <= '0;
      row_cnt_q  <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
      tot_read_q <= '0;
    end else if (clear_i) begin
      col_cnt_q  <= '0;
      w_cnt_q    <= '0;
      row_cnt_q  <= '0;
      col_offs_q <= '0;
      row_offs_q <= '0;
      tot_read_q <= '0;
    end else if (x_flags_i.done) begin
      tot_read_q <= tot_read_q + 1'b1;
      if (cols_last) begin
        col_cnt_q  <= '0;
        col_offs_q <= '0;
        w_cnt_q    <= w_last ? '0 : w_cnt_q + 1'b1;
        if (w_last) begin
          row_cnt_q  <= rows_last ? '0 : row_cnt_q + 1'b1;
          row_offs_q <= rows_last ? '0 : row_offs_q + regs_i[X_ROWS_OFFS];
        end
      end else begin
        col_cnt_q  <= col_cnt_q + 1'b1;
        col_offs_q <= col_offs_q + `MS_ADDR_W'(`MS_TILE_JMP);
      end
    end
  end

  always_comb begin
    x_ctrl_o.cfg.base_addr  = regs_i[X_ADDR] + row_offs_q + col_offs_q;
    // Last row tile may hold fewer rows than the array
    if (rows_last && mode.leftover != '0) begin
      x_ctrl_o.cfg.tot_len = `MS_ADDR_W'(mode.leftover);
    end else begin
      x_ctrl_o.cfg.tot_len = `MS_ADDR_W'(`MS_ARRAY_W);
    end
    x_ctrl_o.cfg.d0_len     = `MS_ADDR_W'(1);
    x_ctrl_o.cfg.d0_stride  = '0;
    x_ctrl_o.cfg.d1_len     = `MS_ADDR_W'(`MS_ARRAY_W);
    x_ctrl_o.cfg.d1_stride  = regs_i[X_D1_STRIDE];
    x_ctrl_o.cfg.d2_stride  = '0;
    x_ctrl_o.cfg.dim_enable = 3'b011;
    x_ctrl_o.req_start      = (first_load_i ||
                               (tot_read_q != '0 && tot_read_q != regs_i[TOT_X_READ])) &&
                              x_flags_i.ready_start;
  end

endmodule

// ==== src/stream_cfg_gen.sv ====
// Address generator configs and start requests of the W/scales, Z, group-index and zeros streams

`timescale 1ns/1ns

`include "mem_sched_defines.svh"

module stream_cfg_gen (
  input  mem_sched_pkg::sched_regs_t   regs_i,
  input  logic                         first_load_i,
  input  mem_sched_pkg::stream_flags_t w_flags_i,
  input  mem_sched_pkg::stream_flags_t z_flags_i,
  input  mem_sched_pkg::stream_flags_t gidx_flags_i,
  input  mem_sched_pkg::stream_flags_t zeros_flags_i,
  output mem_sched_pkg::stream_ctrl_t  w_ctrl_o,
  output mem_sched_pkg::stream_ctrl_t  z_ctrl_o,
  output mem_sched_pkg::stream_ctrl_t  gidx_ctrl_o,
  output mem_sched_pkg::stream_ctrl_t  zeros_ctrl_o
);
  import mem_sched_pkg::*;

  // Group indices packed into one memory word
  localparam int unsigned GidxPerWord = `MS_ADDR_W / `MS_GIDX_W;
  localparam logic [`MS_ADDR_W-1:0] TileJmp = `MS_TILE_JMP;

  iters_reg_t            w_iters;
  mode_reg_t             mode;
  logic [1:0]            q_shift;

  assign w_iters = iters_reg_t'(regs_i[W_ITERS]);
  assign mode    = mode_reg_t'(regs_i[MODE]);
  assign q_shift = get_q_shift(mode.fmt);

  always_comb begin
    // In dequant mode this stream fetches the scales instead of W
    w_ctrl_o.cfg.base_addr  = mode.dequant_en ? regs_i[SCALES_ADDR] : regs_i[W_ADDR];
    w_ctrl_o.cfg.tot_len    = regs_i[W_TOT_LEN];
    w_ctrl_o.cfg.d0_len     = `MS_ADDR_W'(w_iters.hi);
    w_ctrl_o.cfg.d0_stride  = mode.dequant_en ? '0 : regs_i[W_D0_STRIDE];
    w_ctrl_o.cfg.d1_len     = `MS_ADDR_W'(w_iters.lo);
    w_ctrl_o.cfg.d1_stride  = TileJmp;
    w_ctrl_o.cfg.d2_stride  = '0;
    w_ctrl_o.cfg.dim_enable = 3'b011;
    w_ctrl_o.req_start      = first_load_i && w_flags_i.ready_start;

    z_ctrl_o.cfg.base_addr  = regs_i[Z_ADDR];
    z_ctrl_o.cfg.tot_len    = regs_i[Z_TOT_LEN];
    z_ctrl_o.cfg.d0_len     = `MS_ADDR_W'(`MS_ARRAY_W);
    z_ctrl_o.cfg.d0_stride  = regs_i[Z_D0_STRIDE];
    z_ctrl_o.cfg.d1_len     = `MS_ADDR_W'(w_iters.lo);
    z_ctrl_o.cfg.d1_stride  = TileJmp;
    z_ctrl_o.cfg.d2_stride  = '0;
    z_ctrl_o.cfg.dim_enable = 3'b011;
    z_ctrl_o.req_start      = first_load_i && z_flags_i.ready_start;

    gidx_ctrl_o.cfg.base_addr  = regs_i[GIDX_ADDR];
    gidx_ctrl_o.cfg.tot_len    = regs_i[W_TOT_LEN] / GidxPerWord;
    gidx_ctrl_o.cfg.d0_len     = `MS_ADDR_W'(w_iters.hi) / GidxPerWord;
    gidx_ctrl_o.cfg.d0_stride  = TileJmp;
    gidx_ctrl_o.cfg.d1_len     = `MS_ADDR_W'(w_iters.lo);
    gidx_ctrl_o.cfg.d1_stride  = '0;
    gidx_ctrl_o.cfg.d2_stride  = '0;
    gidx_ctrl_o.cfg.dim_enable = 3'b001;
    gidx_ctrl_o.req_start      = mode.dequant_en && first_load_i && gidx_flags_i.ready_start;

    // Zeros are packed like the weights, so the column step shrinks
    zeros_ctrl_o.cfg.base_addr  = regs_i[ZEROS_ADDR];
    zeros_ctrl_o.cfg.tot_len    = regs_i[W_TOT_LEN];
    zeros_ctrl_o.cfg.d0_len     = `MS_ADDR_W'(w_iters.hi);
    zeros_ctrl_o.cfg.d0_stride  = '0;
    zeros_ctrl_o.cfg.d1_len     = `MS_ADDR_W'(w_iters.lo);
    zeros_ctrl_o.cfg.d1_stride  = TileJmp >> q_shift;
    zeros_ctrl_o.cfg.d2_stride  = '0;
    zeros_ctrl_o.cfg.dim_enable = 3'b011;
    zeros_ctrl_o.req_start      = mode.dequant_en && first_load_i && zeros_flags_i.ready_start;
  end

endmodule

// ==== src/dequant_offset_gen.sv ====
// Turns group-index beats into scales and zeros address offsets, zero latency valid/ready

`timescale 1ns/1ns

`include "mem_sched_defines.svh"

module dequant_offset_gen (
  input  mem_sched_pkg::sched_regs_t  regs_i,
  input  logic                        gidx_valid_i,
  output logic                        gidx_ready_o,
  input  mem_sched_pkg::gidx_beat_t   gidx_i,
  output logic                        off_valid_o,
  input  logic                        off_ready_i,
  output mem_sched_pkg::dequant_off_t off_o
);
  import mem_sched_pkg::*;

  mode_reg_t             mode;
  logic [1:0]            q_shift;
  logic [`MS_ITER_W-1:0] row_stride;
  logic [`MS_ITER_W-1:0] zeros_stride;
  logic [`MS_ADDR_W-1:0] index;

  assign mode    = mode_reg_t'(regs_i[MODE]);
  assign q_shift = get_q_shift(mode.fmt);

  // Only the low half of the W row stride is used for group offsets
  assign row_stride   = regs_i[W_D0_STRIDE][`MS_ITER_W-1:0];
  assign zeros_stride = row_stride >> q_shift;
  assign index        = `MS_ADDR_W'(gidx_i.index);

  assign off_o.scales_bias = index * `MS_ADDR_W'(row_stride);
  assign off_o.zeros_bias  = index * `MS_ADDR_W'(zeros_stride);
  assign off_o.skip        = gidx_i.skip;

  // No buffering, the consumer's ready goes straight back to the source
  assign off_valid_o  = gidx_valid_i;
  assign gidx_ready_o = off_ready_i;

endmodule

// ==== src/mem_scheduler.sv ====
// Top of the memory scheduler, joining the register port, tile counters, stream configs and offsets

`timescale 1ns/1ns

module mem_scheduler (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  mem_sched_pkg::wb_req_t       wb_req_i,
  output mem_sched_pkg::wb_rsp_t       wb_rsp_o,
  input  logic                         first_load_i,
  input  mem_sched_pkg::stream_flags_t x_flags_i,
  input  mem_sched_pkg::stream_flags_t w_flags_i,
  input  mem_sched_pkg::stream_flags_t z_flags_i,
  input  mem_sched_pkg::stream_flags_t gidx_flags_i,
  input  mem_sched_pkg::stream_flags_t zeros_flags_i,
  output mem_sched_pkg::stream_ctrl_t  x_ctrl_o,
  output mem_sched_pkg::stream_ctrl_t  w_ctrl_o,
  output mem_sched_pkg::stream_ctrl_t  z_ctrl_o,
  output mem_sched_pkg::stream_ctrl_t  gidx_ctrl_o,
  output mem_sched_pkg::stream_ctrl_t  zeros_ctrl_o,
  input  logic                         gidx_valid_i,
  output logic                         gidx_ready_o,
  input  mem_sched_pkg::gidx_beat_t    gidx_i,
  output logic                         off_valid_o,
  input  logic                         off_ready_i,
  output mem_sched_pkg::dequant_off_t  off_o
);
  import mem_sched_pkg::*;

  sched_regs_t regs;

  sched_param_regs u_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .regs_o   (regs)
  );

  tile_iter_counter u_tile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .regs_i       (regs),
    .first_load_i (first_load_i),
    .x_flags_i    (x_flags_i),
    .x_ctrl_o     (x_ctrl_o)
  );

  stream_cfg_gen u_cfg (
    .regs_i        (regs),
    .first_load_i  (first_load_i),
    .w_flags_i     (w_flags_i),
    .z_flags_i     (z_flags_i),
    .gidx_flags_i  (gidx_flags_i),
    .zeros_flags_i (zeros_flags_i),
    .w_ctrl_o      (w_ctrl_o),
    .z_ctrl_o      (z_ctrl_o),
    .gidx_ctrl_o   (gidx_ctrl_o),
    .zeros_ctrl_o  (zeros_ctrl_o)
  );

  dequant_offset_gen u_deq (
    .regs_i       (regs),
    .gidx_valid_i (gidx_valid_i),
    .gidx_ready_o (gidx_ready_o),
    .gidx_i       (gidx_i),
    .off_valid_o  (off_valid_o),
    .off_ready_i  (off_ready_i),
    .off_o        (off_o)
  );

endmodule

// ==== bench/mem_scheduler_asserts.sv ====
// Concurrent checks on the Wishbone ack, the offset handshake and the stream starts, bound to the top

`timescale 1ns/1ns

module mem_scheduler_asserts (
  input logic                         clk_i,
  input logic                         rst_ni,
  input mem_sched_pkg::wb_rsp_t       wb_rsp_o,
  input logic                         off_valid_o,
  input logic                         off_ready_i,
  input mem_sched_pkg::dequant_off_t  off_o,
  input mem_sched_pkg::stream_flags_t x_flags_i,
  input mem_sched_pkg::stream_flags_t w_flags_i,
  input mem_sched_pkg::stream_flags_t z_flags_i,
  input mem_sched_pkg::stream_flags_t gidx_flags_i,
  input mem_sched_pkg::stream_flags_t zeros_flags_i,
  input mem_sched_pkg::stream_ctrl_t  x_ctrl_o,
  input mem_sched_pkg::stream_ctrl_t  w_ctrl_o,
  input mem_sched_pkg::stream_ctrl_t  z_ctrl_o,
  input mem_sched_pkg::stream_ctrl_t  gidx_ctrl_o,
  input mem_sched_pkg::stream_ctrl_t  zeros_ctrl_o
);

  // Ack is a single cycle pulse
  ack_single_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_o.ack |=> !wb_rsp_o.ack)
    else $error("Wishbone ack held for two cycles");

  // A stalled offset beat keeps its value
  off_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (off_valid_o && !off_ready_i) |=> (off_valid_o && $stable(off_o)))
    else $error("offset output changed under back-pressure");

  start_gated_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!x_ctrl_o.req_start || x_flags_i.ready_start) &&
    (!w_ctrl_o.req_start || w_flags_i.ready_start) &&
    (!z_ctrl_o.req_start || z_flags_i.ready_start) &&
    (!gidx_ctrl_o.req_start || gidx_flags_i.ready_start) &&
    (!zeros_ctrl_o.req_start || zeros_flags_i.ready_start))
    else $error("stream start requested without ready_start");

endmodule

bind mem_scheduler mem_scheduler_asserts u_asserts (.*);

// ==== bench/tb_mem_scheduler.sv ====
// Table-driven testbench of the memory scheduler, run from vlog.f with Verilator

`timescale 1ns/1ns

module tb_mem_scheduler;
  import mem_sched_pkg::*;

  localparam int KIND_WRITE = 0;
  localparam int KIND_DONE = 1;
  localparam int KIND_START = 2;
  localparam int KIND_GIDX = 3;
  localparam int MAX_STEP_CYCLES = 400;
  localparam int GIDX_BEATS = 20;

  typedef struct {
    string       name;
    int          kind;
    logic [3:0]  adr;
    logic [31:0] dat;
  } step_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic clear_i;
  logic first_load_i;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  stream_flags_t x_flags, w_flags, z_flags, g_flags, zr_flags;
  stream_ctrl_t x_ctrl, w_ctrl, z_ctrl, g_ctrl, zr_ctrl;
  logic gidx_valid, gidx_ready, off_valid, off_ready;
  gidx_beat_t gidx_beat;
  dequant_off_t off;

  step_t steps[$];
  bit table_ready = 1'b0;
  int errors = 0;
  int checks = 0;
  logic [15:0] lfsr_q = 16'd64;

  // Reference model state
  logic [31:0] regs_m [16];
  logic [31:0] m_col, m_w, m_row, m_tot, m_coff, m_roff;

  mem_scheduler u_mem_scheduler (
    .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i),
    .wb_req_i (wb_req), .wb_rsp_o (wb_rsp), .first_load_i (first_load_i),
    .x_flags_i (x_flags), .w_flags_i (w_flags), .z_flags_i (z_flags),
    .gidx_flags_i (g_flags), .zeros_flags_i (zr_flags),
    .x_ctrl_o (x_ctrl), .w_ctrl_o (w_ctrl), .z_ctrl_o (z_ctrl),
    .gidx_ctrl_o (g_ctrl), .zeros_ctrl_o (zr_ctrl),
    .gidx_valid_i (gidx_valid), .gidx_ready_o (gidx_ready), .gidx_i (gidx_beat),
    .off_valid_o (off_valid), .off_ready_i (off_ready), .off_o (off)
  );

  always #2 clk_i = ~clk_i;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      r = {r[6:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic void add_step(string name, int kind, logic [3:0] adr, logic [31:0] dat);
    step_t s;
    s.name = name;
    s.kind = kind;
    s.adr = adr;
    s.dat = dat;
    steps.push_back(s);
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] shift_for(input logic [1:0] fmt);
    if (fmt == 2'd2) return 32'd3;
    if (fmt == 2'd1) return 32'd2;
    return 32'd1;
  endfunction

  function automatic logic exp_x_req(input logic fl, input logic rdy);
    return (fl || (m_tot != 32'd0 && m_tot != regs_m[14])) && rdy;
  endfunction

  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
    int waited;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    waited = 0;
    do begin
      @(posedge clk_i);
      #1;
      waited++;
    end while (!wb_rsp.ack && waited < 10);
    if (!wb_rsp.ack) begin
      errors++;
      $display("error: no Wishbone ack within 10 cycles");
    end else if (waited != 1) begin
      errors++;
      $display("error: Wishbone ack came %0d cycles after the request", waited);
    end
    rdat = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic do_done(input string name);
    logic [31:0] left;
    first_load_i = 1'b0;
    x_flags.ready_start = 1'b1;
    x_flags.done = 1'b1;
    @(posedge clk_i);
    #1;
    x_flags.done = 1'b0;
    m_tot = m_tot + 32'd1;
    if (m_col == {16'd0, regs_m[6][15:0]} - 32'd1) begin
      m_col = 0;
      m_coff = 0;
      if (m_w == {16'd0, regs_m[7][15:0]} - 32'd1) begin
        m_w = 0;
        if (m_row == {16'd0, regs_m[6][31:16]} - 32'd1) begin
          m_row = 0;
          m_roff = 0;
        end else begin
          m_row = m_row + 32'd1;
          m_roff = m_roff + regs_m[8];
        end
      end else begin
        m_w = m_w + 32'd1;
      end
    end else begin
      m_col = m_col + 32'd1;
      m_coff = m_coff + 32'd64;
    end
    left = {24'd0, regs_m[15][31:24]};
    check_val({name, " base"}, regs_m[0] + m_roff + m_coff, x_ctrl.cfg.base_addr);
    if (m_row == {16'd0, regs_m[6][31:16]} - 32'd1 && left != 32'd0) begin
      check_val({name, " tot_len"}, left, x_ctrl.cfg.tot_len);
    end else begin
      check_val({name, " tot_len"}, 32'd4, x_ctrl.cfg.tot_len);
    end
    check_val({name, " d1_stride"}, regs_m[9], x_ctrl.cfg.d1_stride);
    check_val({name, " req_start"}, {31'd0, exp_x_req(1'b0, 1'b1)}, {31'd0, x_ctrl.req_start});
  endtask

  task automatic check_starts(input string name);
    logic fl, rdy, deq;
    deq = regs_m[15][0];
    for (int c = 0; c < 4; c++) begin
      fl = c[1];
      rdy = c[0];
      first_load_i = fl;
      x_flags.ready_start = rdy;
      w_flags.ready_start = rdy;
      z_flags.ready_start = rdy;
      g_flags.ready_start = rdy;
      zr_flags.ready_start = rdy;
      #1;
      check_val({name, " x"}, {31'd0, exp_x_req(fl, rdy)}, {31'd0, x_ctrl.req_start});
      check_val({name, " w"}, {31'd0, fl && rdy}, {31'd0, w_ctrl.req_start});
      check_val({name, " z"}, {31'd0, fl && rdy}, {31'd0, z_ctrl.req_start});
      check_val({name, " gidx"}, {31'd0, deq && fl && rdy}, {31'd0, g_ctrl.req_start});
      check_val({name, " zeros"}, {31'd0, deq && fl && rdy}, {31'd0, zr_ctrl.req_start});
      @(posedge clk_i);
      #1;
    end
    check_val({name, " w base"}, deq ? regs_m[3] : regs_m[1], w_ctrl.cfg.base_addr);
    check_val({name, " w d0_stride"}, deq ? 32'd0 : regs_m[10], w_ctrl.cfg.d0_stride);
    check_val({name, " zeros d1_stride"}, 32'd64 >> shift_for(regs_m[15][2:1]),
              zr_ctrl.cfg.d1_stride);
    first_load_i = 1'b0;
  endtask

  task automatic run_gidx(input string name);
    int sent, got, cycles;
    logic [7:0] r;
    logic [31:0] stride, idx;
    sent = 0;
    got = 0;
    cycles = 0;
    stride = {16'd0, regs_m[10][15:0]};
    while (got < GIDX_BEATS && cycles < MAX_STEP_CYCLES - 10) begin
      if (!gidx_valid && sent < GIDX_BEATS) begin
        r = rand_bits(1);
        if (r[0]) begin
          gidx_beat.index = rand_bits(8);
          r = rand_bits(1);
          gidx_beat.skip = r[0];
          gidx_valid = 1'b1;
          sent++;
        end
      end
      r = rand_bits(1);
      off_ready = r[0];
      #1;
      if (off_valid !== gidx_valid || gidx_ready !== off_ready) begin
        errors++;
        $display("error: %s handshake not passed straight through", name);
      end
      if (gidx_valid && off_ready) begin
        idx = {24'd0, gidx_beat.index};
        check_val({name, " scales"}, idx * stride, off.scales_bias);
        check_val({name, " zeros"}, idx * (stride >> shift_for(regs_m[15][2:1])),
                  off.zeros_bias);
        check_val({name, " skip"}, {31'd0, gidx_beat.skip}, {31'd0, off.skip});
        got++;
      end
      @(posedge clk_i);
      #1;
      if (gidx_valid && off_ready) gidx_valid = 1'b0;
      cycles++;
    end
    gidx_valid = 1'b0;
    off_ready = 1'b0;
    check_val({name, " beats"}, GIDX_BEATS, got);
  endtask

  initial begin
    int limit;
    wait (table_ready);
    limit = (steps.size() * MAX_STEP_CYCLES + 20) * 4;
    #(limit);
    $display("timeout: the run did not finish within %0d ns", limit);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    first_load_i = 1'b0;
    wb_req = '0;
    x_flags = '0;
    w_flags = '0;
    z_flags = '0;
    g_flags = '0;
    zr_flags = '0;
    gidx_valid = 1'b0;
    gidx_beat = '0;
    off_ready = 1'b0;
    for (int i = 0; i < 16; i++) regs_m[i] = '0;
    m_col = 0;
    m_w = 0;
    m_row = 0;
    m_tot = 0;
    m_coff = 0;
    m_roff = 0;

    add_step("wr_x_addr", KIND_WRITE, 4'd0, 32'h0000_1000);
    add_step("wr_w_addr", KIND_WRITE, 4'd1, 32'h0000_2000);
    add_step("wr_z_addr", KIND_WRITE, 4'd2, 32'h0000_3000);
    add_step("wr_scales", KIND_WRITE, 4'd3, 32'h0000_4000);
    add_step("wr_zeros", KIND_WRITE, 4'd4, 32'h0000_5000);
    add_step("wr_gidx", KIND_WRITE, 4'd5, 32'h0000_6000);
    add_step("wr_x_iters", KIND_WRITE, 4'd6, 32'h0003_0002);
    add_step("wr_w_iters", KIND_WRITE, 4'd7, 32'h0008_0002);
    add_step("wr_rows_offs", KIND_WRITE, 4'd8, 32'h0000_0200);
    add_step("wr_x_d1", KIND_WRITE, 4'd9, 32'h0000_0040);
    add_step("wr_w_d0", KIND_WRITE, 4'd10, 32'hABCD_0080);
    add_step("wr_w_tot", KIND_WRITE, 4'd11, 32'd32);
    add_step("wr_z_tot", KIND_WRITE, 4'd12, 32'd16);
    add_step("wr_z_d0", KIND_WRITE, 4'd13, 32'h0000_0100);
    add_step("wr_tot_x", KIND_WRITE, 4'd14, 32'd12);
    add_step("wr_mode", KIND_WRITE, 4'd15, 32'h0300_0000);
    add_step("x_start_idle", KIND_START, 4'd0, 32'd0);
    for (int i = 0; i < 5; i++) add_step("x_tile", KIND_DONE, 4'd0, 32'd0);
    add_step("x_start_mid", KIND_START, 4'd0, 32'd0);
    for (int i = 0; i < 7; i++) add_step("x_tile", KIND_DONE, 4'd0, 32'd0);
    add_step("x_start_end", KIND_START, 4'd0, 32'd0);
    add_step("wr_mode_q4", KIND_WRITE, 4'd15, 32'h0300_0003);
    add_step("dequant_start", KIND_START, 4'd0, 32'd0);
    add_step("gidx_q4", KIND_GIDX, 4'd0, 32'd0);
    add_step("wr_mode_q2", KIND_WRITE, 4'd15, 32'h0300_0005);
    add_step("gidx_q2", KIND_GIDX, 4'd0, 32'd0);
    add_step("wr_mode_q8", KIND_WRITE, 4'd15, 32'h0300_0001);
    add_step("gidx_q8", KIND_GIDX, 4'd0, 32'd0);
    table_ready = 1'b1;

    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    foreach (steps[i]) begin
      case (steps[i].kind)
        KIND_WRITE: begin
          wb_access(1'b1, steps[i].adr, steps[i].dat, rd);
          regs_m[steps[i].adr] = steps[i].dat;
          @(posedge clk_i);
          #1;
          wb_access(1'b0, steps[i].adr, 32'd0, rd);
          check_val(steps[i].name, steps[i].dat, rd);
        end
        KIND_DONE:  do_done(steps[i].name);
        KIND_START: check_starts(steps[i].name);
        default:    run_gidx(steps[i].name);
      endcase
      @(posedge clk_i);
      #1;
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/mem_sched_pkg.sv
src/sched_param_regs.sv
src/tile_iter_counter.sv
src/stream_cfg_gen.sv
src/dequant_offset_gen.sv
src/mem_scheduler.sv
bench/mem_scheduler_asserts.sv
bench/tb_mem_scheduler.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and decide the verdict from the log
set -e

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_mem_scheduler -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "=== PASS ===" sim.log
